/* hw/commit_pkg.sv */
// commit stage package
// widths, commit record and writeback types shared by the RTL and testbench

package commit_pkg;

    // core geometry
    localparam int NUM_THREADS      = 4;
    localparam int NUM_WARPS        = 4;
    localparam int NW_BITS          = 2;
    localparam int XLEN             = 32;
    localparam int NR_BITS          = 5;
    localparam int UUID_BITS        = 8;
    localparam int NUM_EX_UNITS     = 3;
    // enough bits to count every thread of a warp
    localparam int COMMIT_SIZE_BITS = 3;

    // arbiter input order
    typedef enum logic [1:0] {
        ex_lsu = 2'd0,
        ex_alu = 2'd1,
        ex_sfu = 2'd2
    } ex_unit_e;

    // record presented by an execution unit
    typedef struct packed {
        logic [UUID_BITS-1:0]               uuid;
        logic [NW_BITS-1:0]                 wid;
        logic [NUM_THREADS-1:0]             tmask;
        logic [XLEN-1:0]                    pc;
        logic                               wb;
        logic [NR_BITS-1:0]                 rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]   data;
        logic                               sop;
        logic                               eop;
    } commit_data_t;

    // register file write port
    typedef struct packed {
        logic [UUID_BITS-1:0]               uuid;
        logic [NW_BITS-1:0]                 wid;
        logic [XLEN-1:0]                    pc;
        logic [NUM_THREADS-1:0]             tmask;
        logic [NR_BITS-1:0]                 rd;
        logic [NUM_THREADS-1:0][XLEN-1:0]   data;
        logic                               sop;
        logic                               eop;
    } writeback_data_t;

    // warp completion notify for the scheduler
    typedef struct packed {
        logic               committed;
        logic [NW_BITS-1:0] wid;
    } commit_sched_t;

endpackage

/* hw/commit_arb.sv */
// commit arbiter
// round-robin merge of valid/ready commit streams into one registered output slot

`timescale 1ns/10ps

module commit_arb import commit_pkg::*; #(
    parameter int NUM_INPUTS = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [NUM_INPUTS-1:0]               in_valid,
    input  commit_data_t [NUM_INPUTS-1:0]       in_data,
    output logic [NUM_INPUTS-1:0]               in_ready,
    output logic                                out_valid,
    output commit_data_t                        out_data,
    input  logic                                out_ready
);

    localparam int IDX_BITS = $clog2(NUM_INPUTS);

    logic [IDX_BITS-1:0]    last_grant;
    logic [IDX_BITS-1:0]    grant_idx;
    logic                   grant_any;
    logic                   arb_en;
    logic                   load_en;
    logic                   xfer;
    logic                   slot_valid;
    commit_data_t           slot_data;

    // search starts one past the last grant and wraps around,
    // the last granted input comes last
    always_comb begin
        int idx;
        grant_idx = last_grant;
        grant_any = 1'b0;
        for (int i = 1; i <= NUM_INPUTS; i++) begin
            idx = (int'(last_grant) + i) % NUM_INPUTS;
            if (!grant_any && in_valid[idx]) begin
                grant_any = 1'b1;
                grant_idx = IDX_BITS'(idx);
            end
        end
    end

    // slot can take a new record when empty or being drained
    assign load_en = arb_en && (!slot_valid || out_ready);
    assign xfer    = load_en && grant_any;

    // one-hot ready to the winner only
    for (genvar g = 0; g < NUM_INPUTS; g++) begin : g_ready
        assign in_ready[g] = xfer && (grant_idx == IDX_BITS'(g));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arb_en     <= 1'b0;
            slot_valid <= 1'b0;
            last_grant <= '0;
        end else begin
            // readies held off until reset has been released
            arb_en <= 1'b1;
            if (load_en) begin
                slot_valid <= grant_any;
            end
            if (xfer) begin
                last_grant <= grant_idx;
            end
        end
    end

    // payload slot
    always_ff @(posedge clk) begin
        if (xfer) begin
            slot_data <= in_data[grant_idx];
        end
    end

    assign out_valid = slot_valid;
    assign out_data  = slot_data;

endmodule

/* hw/commit_pipe_reg.sv */
// single pipeline stage
// registers a valid bit and a payload of any type every cycle

`timescale 1ns/10ps

module commit_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        valid_in,
    input  payload_t    data_in,
    output logic        valid_out,
    output payload_t    data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= data_in;
    end

endmodule

/* hw/instret_counter.sv */
// retired instruction counter
// popcount of active threads, a sum stage, then accumulate into instret

`timescale 1ns/10ps

module instret_counter import commit_pkg::*; #(
    parameter int CTR_WIDTH = 40
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    fire,
    input  logic [NUM_THREADS-1:0]  tmask,
    output logic [CTR_WIDTH-1:0]    instret
);

    // per-lane thread count
    typedef struct packed {
        logic [COMMIT_SIZE_BITS-1:0] size;
    } size_stage_t;

    // total over all issue lanes
    typedef struct packed {
        logic [COMMIT_SIZE_BITS-1:0] total;
    } sum_stage_t;

    logic [NUM_THREADS-1:0]         active_mask;
    logic [COMMIT_SIZE_BITS-1:0]    pop_count;
    size_stage_t                    size_d;
    size_stage_t                    size_q;
    sum_stage_t                     sum_d;
    sum_stage_t                     sum_q;
    logic                           fire_r;
    logic                           fire_rr;
    logic [CTR_WIDTH-1:0]           count_r;

    assign active_mask = tmask & {NUM_THREADS{fire}};

    always_comb begin
        pop_count = '0;
        for (int i = 0; i < NUM_THREADS; i++) begin
            pop_count = pop_count + COMMIT_SIZE_BITS'(active_mask[i]);
        end
    end

    assign size_d.size = pop_count;

    commit_pipe_reg #(
        .payload_t  (size_stage_t)
    ) size_reg (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (fire),
        .data_in    (size_d),
        .valid_out  (fire_r),
        .data_out   (size_q)
    );

    // single issue lane, so the reduction is just the lane count
    assign sum_d.total = size_q.size;

    commit_pipe_reg #(
        .payload_t  (sum_stage_t)
    ) sum_reg (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (fire_r),
        .data_in    (sum_d),
        .valid_out  (fire_rr),
        .data_out   (sum_q)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            count_r <= '0;
        end else if (fire_rr) begin
            count_r <= count_r + CTR_WIDTH'(sum_q.total);
        end
    end

    assign instret = count_r;

endmodule

/* hw/commit_stage.sv */
// SIMT commit stage
// merges ALU/LSU/SFU commit records into writeback, scheduler notify and instret

`timescale 1ns/10ps

module commit_stage import commit_pkg::*; #(
    parameter int CTR_WIDTH = 40
) (
    input  logic                    clk,
    input  logic                    reset,

    // execution unit streams
    input  logic                    lsu_valid,
    input  commit_data_t            lsu_data,
    output logic                    lsu_ready,
    input  logic                    alu_valid,
    input  commit_data_t            alu_data,
    output logic                    alu_ready,
    input  logic                    sfu_valid,
    input  commit_data_t            sfu_data,
    output logic                    sfu_ready,

    // register file writeback
    output logic                    wb_valid,
    output writeback_data_t         wb_data,

    // scheduler and counters
    output commit_sched_t           sched,
    output logic [CTR_WIDTH-1:0]    instret
);

    logic [NUM_EX_UNITS-1:0]            arb_valid;
    commit_data_t [NUM_EX_UNITS-1:0]    arb_data;
    logic [NUM_EX_UNITS-1:0]            arb_ready;
    logic                               rec_valid;
    commit_data_t                       rec;
    logic                               commit_fire;
    logic                               commit_eop;
    commit_sched_t                      sched_d;
    commit_sched_t                      sched_q;
    logic                               sched_vld;

    // arbiter inputs in unit index order
    assign arb_valid[ex_lsu] = lsu_valid;
    assign arb_valid[ex_alu] = alu_valid;
    assign arb_valid[ex_sfu] = sfu_valid;
    assign arb_data[ex_lsu]  = lsu_data;
    assign arb_data[ex_alu]  = alu_data;
    assign arb_data[ex_sfu]  = sfu_data;

    assign lsu_ready = arb_ready[ex_lsu];
    assign alu_ready = arb_ready[ex_alu];
    assign sfu_ready = arb_ready[ex_sfu];

    commit_arb #(
        .NUM_INPUTS (NUM_EX_UNITS)
    ) arb (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (arb_valid),
        .in_data    (arb_data),
        .in_ready   (arb_ready),
        .out_valid  (rec_valid),
        .out_data   (rec),
        .out_ready  (1'b1)
    );

    // writeback side never stalls, every valid slot retires
    assign commit_fire = rec_valid;
    assign commit_eop  = commit_fire & rec.eop;

    assign wb_valid = rec_valid & rec.wb;
    assign wb_data  = '{
        uuid:  rec.uuid,
        wid:   rec.wid,
        pc:    rec.pc,
        tmask: rec.tmask,
        rd:    rec.rd,
        data:  rec.data,
        sop:   rec.sop,
        eop:   rec.eop
    };

    // warp committed notify, one cycle behind the slot
    assign sched_d = '{committed: commit_eop, wid: rec.wid};

    commit_pipe_reg #(
        .payload_t  (commit_sched_t)
    ) sched_reg (
        .clk        (clk),
        .reset      (reset),
        .valid_in   (commit_eop),
        .data_in    (sched_d),
        .valid_out  (sched_vld),
        .data_out   (sched_q)
    );

    assign sched = '{committed: sched_vld & sched_q.committed, wid: sched_q.wid};

    instret_counter #(
        .CTR_WIDTH  (CTR_WIDTH)
    ) instret_ctr (
        .clk        (clk),
        .reset      (reset),
        .fire       (commit_fire),
        .tmask      (rec.tmask),
        .instret    (instret)
    );

endmodule

/* include/commit_tb_tasks.svh */
// commit stage testbench helpers
// compare tasks and a round-robin grant model; the includer imports commit_pkg
// and declares CTR_WIDTH

`ifndef COMMIT_TB_TASKS_SVH
`define COMMIT_TB_TASKS_SVH

// next unit granted after last_grant, -1 when none is valid
// after reset last_grant is ex_lsu, so the search begins at alu
function automatic int rr_next(input logic [NUM_EX_UNITS-1:0] valid_mask,
                               input int last_grant);
    int idx;
    for (int i = 1; i <= NUM_EX_UNITS; i++) begin
        idx = (last_grant + i) % NUM_EX_UNITS;
        if (valid_mask[idx]) begin
            return idx;
        end
    end
    return -1;
endfunction

// field copy the stage applies on writeback
function automatic writeback_data_t expected_wb(input commit_data_t rec);
    return '{uuid: rec.uuid, wid: rec.wid, pc: rec.pc, tmask: rec.tmask,
             rd: rec.rd, data: rec.data, sop: rec.sop, eop: rec.eop};
endfunction

function automatic int tmask_popcount(input logic [NUM_THREADS-1:0] tmask);
    int cnt;
    cnt = 0;
    for (int i = 0; i < NUM_THREADS; i++) begin
        cnt += int'(tmask[i]);
    end
    return cnt;
endfunction

task automatic check_wb(input writeback_data_t got, input writeback_data_t exp,
                        inout int errors);
    if (got !== exp) begin
        $display("Fail: %0t wb got uuid=%0h wid=%0d rd=%0d, expected uuid=%0h wid=%0d rd=%0d",
                 $time, got.uuid, got.wid, got.rd, exp.uuid, exp.wid, exp.rd);
        errors++;
    end
endtask

task automatic check_sched(input commit_sched_t got, input commit_sched_t exp,
                           inout int errors);
    if (got !== exp) begin
        $display("Fail: %0t sched got committed=%b wid=%0d, expected committed=%b wid=%0d",
                 $time, got.committed, got.wid, exp.committed, exp.wid);
        errors++;
    end
endtask

task automatic check_count(input logic [CTR_WIDTH-1:0] got,
                           input logic [CTR_WIDTH-1:0] exp, inout int errors);
    if (got !== exp) begin
        $display("Fail: %0t instret got %0d, expected %0d", $time, got, exp);
        errors++;
    end
endtask

`endif

/* testbench/commit_stage_tb.sv */
// commit stage testbench
// table-driven commits from three units, checked against a round-robin model

`timescale 1ns/10ps

module commit_stage_tb import commit_pkg::*;;

    localparam int CTR_WIDTH       = 40;
    localparam int CLK_PERIOD      = 100;
    localparam int NUM_ROWS        = 11;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 10 + 50;

    `include "commit_tb_tasks.svh"

    // one stimulus row with bits and slices indexed by unit
    typedef struct packed {
        logic [NUM_EX_UNITS-1:0]                    mask;
        logic [NUM_EX_UNITS-1:0]                    wb;
        logic [NUM_EX_UNITS-1:0]                    eop;
        logic [NUM_EX_UNITS-1:0][NUM_THREADS-1:0]   tmask;
        logic [1:0]                                 first;  // 3 when no unit is valid
    } stim_row_t;

    // first grant worked out by hand from the last-grant rule
    stim_row_t table_rows [NUM_ROWS] = '{
        '{3'b001, 3'b001, 3'b001, 12'h00f, 2'd0},
        '{3'b010, 3'b000, 3'b010, 12'h050, 2'd1},
        '{3'b100, 3'b100, 3'b000, 12'h300, 2'd2},
        '{3'b000, 3'b000, 3'b000, 12'h000, 2'd3},
        '{3'b111, 3'b111, 3'b111, 12'h421, 2'd0},
        '{3'b011, 3'b010, 3'b001, 12'h07f, 2'd0},
        '{3'b111, 3'b101, 3'b110, 12'h8e3, 2'd2},
        '{3'b110, 3'b110, 3'b010, 12'h690, 2'd2},
        '{3'b101, 3'b001, 3'b101, 12'hf0c, 2'd2},
        '{3'b111, 3'b111, 3'b011, 12'hbd5, 2'd1},
        '{3'b010, 3'b010, 3'b010, 12'h000, 2'd1}
    };

    string row_name [NUM_ROWS] = '{
        "lsu wb eop", "alu eop no wb", "sfu wb no eop", "idle",
        "all units", "lsu and alu", "all mixed", "alu and sfu",
        "lsu and sfu", "all wrap", "alu empty mask"
    };

    logic                   clk;
    logic                   reset;
    logic                   lsu_valid;
    commit_data_t           lsu_data;
    logic                   lsu_ready;
    logic                   alu_valid;
    commit_data_t           alu_data;
    logic                   alu_ready;
    logic                   sfu_valid;
    commit_data_t           sfu_data;
    logic                   sfu_ready;
    logic                   wb_valid;
    writeback_data_t        wb_data;
    commit_sched_t          sched;
    logic [CTR_WIDTH-1:0]   instret;

    // scoreboard state
    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    int                     last_grant;
    int                     first_grant;
    int                     pop_d;
    int                     pop_dd;
    logic                   arb_live;
    logic [NUM_EX_UNITS-1:0] pending;
    commit_data_t           unit_rec [NUM_EX_UNITS];
    commit_data_t           exp_slot;
    logic                   exp_slot_v;
    logic                   exp_sched_c;
    logic [NW_BITS-1:0]     exp_sched_wid;
    logic [CTR_WIDTH-1:0]   exp_count;

    commit_stage #(
        .CTR_WIDTH  (CTR_WIDTH)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .lsu_valid  (lsu_valid),
        .lsu_data   (lsu_data),
        .lsu_ready  (lsu_ready),
        .alu_valid  (alu_valid),
        .alu_data   (alu_data),
        .alu_ready  (alu_ready),
        .sfu_valid  (sfu_valid),
        .sfu_data   (sfu_data),
        .sfu_ready  (sfu_ready),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .sched      (sched),
        .instret    (instret)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // record with table control fields and random payload
    function automatic commit_data_t make_rec(input stim_row_t row, input int u);
        commit_data_t rec;
        rec.uuid  = UUID_BITS'($urandom);
        rec.wid   = NW_BITS'($urandom);
        rec.tmask = row.tmask[u];
        rec.pc    = $urandom;
        rec.wb    = row.wb[u];
        rec.rd    = NR_BITS'($urandom);
        for (int t = 0; t < NUM_THREADS; t++) begin
            rec.data[t] = $urandom;
        end
        rec.sop   = 1'($urandom);
        rec.eop   = row.eop[u];
        return rec;
    endfunction

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %-16s pass", name);
        end else begin
            tests_failed++;
            $display("test %-16s %0d errors", name, errors - err_start);
        end
    endtask

    // one clock cycle, entered and left at a falling edge
    task automatic run_cycle();
        commit_sched_t              exp_s;
        commit_sched_t              got_s;
        logic [NUM_EX_UNITS-1:0]    got_ready;
        logic [NUM_EX_UNITS-1:0]    exp_ready;
        int                         g;
        if (wb_valid !== (exp_slot_v & exp_slot.wb)) begin
            $display("Fail: %0t wb_valid is %b, expected %b", $time, wb_valid,
                     exp_slot_v & exp_slot.wb);
            errors++;
        end else if (wb_valid) begin
            check_wb(wb_data, expected_wb(exp_slot), errors);
        end
        exp_s = '{committed: exp_sched_c, wid: exp_sched_wid};
        got_s = sched;
        // wid only matters with a pulse
        if (!exp_s.committed) begin
            got_s.wid = exp_s.wid;
        end
        check_sched(got_s, exp_s, errors);
        check_count(instret, exp_count, errors);

        // model steps through the next edge
        // popcount passes two stages before the accumulator
        exp_count     = exp_count + CTR_WIDTH'(pop_dd);
        pop_dd        = pop_d;
        pop_d         = exp_slot_v ? tmask_popcount(exp_slot.tmask) : 0;
        exp_sched_c   = exp_slot_v & exp_slot.eop;
        exp_sched_wid = exp_slot.wid;

        lsu_valid = pending[ex_lsu];
        lsu_data  = unit_rec[ex_lsu];
        alu_valid = pending[ex_alu];
        alu_data  = unit_rec[ex_alu];
        sfu_valid = pending[ex_sfu];
        sfu_data  = unit_rec[ex_sfu];
        #1;
        got_ready = {sfu_ready, alu_ready, lsu_ready};
        g = arb_live ? rr_next(pending, last_grant) : -1;
        exp_ready = (g >= 0) ? NUM_EX_UNITS'(1 << g) : '0;
        if (got_ready !== exp_ready) begin
            $display("Fail: %0t readies are %b, expected %b", $time, got_ready, exp_ready);
            errors++;
        end
        exp_slot_v = (g >= 0);
        if (g >= 0) begin
            exp_slot   = unit_rec[g];
            last_grant = g;
            if (first_grant < 0) begin
                first_grant = g;
            end
        end
        // a unit drops its record once ready is seen
        pending  = pending & ~got_ready;
        arb_live = 1'b1;
        @(negedge clk);
    endtask

    initial begin
        int                     err_start;
        int                     exp_first;
        commit_sched_t          got_s;
        logic [CTR_WIDTH-1:0]   total_threads;
        void'($urandom(32'h9142));
        reset = 1'b1;
        lsu_valid = 1'b0;
        alu_valid = 1'b0;
        sfu_valid = 1'b0;
        lsu_data = '0;
        alu_data = '0;
        sfu_data = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        last_grant = int'(ex_lsu);
        pop_d = 0;
        pop_dd = 0;
        arb_live = 1'b0;
        pending = '0;
        exp_slot = '0;
        exp_slot_v = 1'b0;
        exp_sched_c = 1'b0;
        exp_sched_wid = '0;
        exp_count = '0;
        total_threads = '0;
        for (int u = 0; u < NUM_EX_UNITS; u++) begin
            unit_rec[u] = '0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        err_start = errors;
        if ({sfu_ready, alu_ready, lsu_ready} !== 3'b000 || wb_valid !== 1'b0) begin
            $display("Fail: %0t readies or wb_valid high during reset", $time);
            errors++;
        end
        got_s = '{committed: sched.committed, wid: '0};
        check_sched(got_s, '{committed: 1'b0, wid: '0}, errors);
        check_count(instret, '0, errors);
        report_test("reset", err_start);
        reset = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_start = errors;
            pending = table_rows[r].mask;
            first_grant = -1;
            for (int u = 0; u < NUM_EX_UNITS; u++) begin
                if (pending[u]) begin
                    unit_rec[u] = make_rec(table_rows[r], u);
                    total_threads += CTR_WIDTH'(tmask_popcount(table_rows[r].tmask[u]));
                end
            end
            do begin
                run_cycle();
            end while (pending != 0);
            exp_first = (table_rows[r].first == 2'd3) ? -1 : int'(table_rows[r].first);
            if (first_grant != exp_first) begin
                $display("Fail: %0t row %0d first grant %0d, expected %0d", $time, r,
                         first_grant, exp_first);
                errors++;
            end
            report_test(row_name[r], err_start);
        end

        // drain the counter pipeline
        err_start = errors;
        repeat (4) run_cycle();
        check_count(instret, total_threads, errors);
        report_test("instret total", err_start);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* commit_stage.f */
+incdir+include
hw/commit_pkg.sv
hw/commit_arb.sv
hw/commit_pipe_reg.sv
hw/instret_counter.sv
hw/commit_stage.sv
testbench/commit_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the commit stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module commit_stage_tb \
    -f commit_stage.f \
    -o commit_stage_sim

sim_out=$(./obj_dir/commit_stage_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi
